//--- design/claConfigPkg.sv
// Configuration as software programs it: sizes, match sets, EAP entries
// and the control word.
// The size constants are the defaults of the top-level parameters. The
// packed types below are built from them and do not follow overrides.
// The EAP action field is a raw 3-bit code. claPipePkg gives its meaning.

`default_nettype none

package claConfigPkg;

  // ******************************
  // Sizes
  // ******************************
  localparam int SignalWidth   = 16;
  localparam int NumMatchSets  = 4;
  localparam int XtriggerWidth = 2;
  localparam int NumNodes      = 4;
  localparam int EapsPerNode   = 2;
  localparam int NumEvents     = NumMatchSets + XtriggerWidth;

  // ******************************
  // Programmable entries
  // ******************************

  // Bits under mask are compared against match
  typedef struct packed {
    logic [SignalWidth-1:0] mask;
    logic [SignalWidth-1:0] match;
  } matchSetT;

  // One event/action point
  typedef struct packed {
    logic       enable;
    logic [2:0] eventSel;
    logic [2:0] op;
    logic [1:0] nextNode;
  } eapConfigT;

  typedef struct packed {
    logic enableEap;
    logic haltEnable;
  } claCtrlT;

endpackage

`default_nettype wire

//--- design/claPipePkg.sv
// Action opcodes and the items that travel between the analyzer stages.
// Field widths come from claConfigPkg and are fixed at the default sizes
// of four nodes, two EAPs per node and a 16-bit debug word.

`default_nettype none

package claPipePkg;

  import claConfigPkg::*;

  // Encoding of the op field in eapConfigT
  typedef enum logic [2:0] {
    actionNone,
    actionHaltClock,
    actionDebugInterrupt,
    actionTraceStart,
    actionTraceStop,
    actionXtrigger
  } actionOpT;

  // ******************************
  // Stage items
  // ******************************

  // Decode to execute, match sets in the low bits
  typedef struct packed {
    logic [NumEvents-1:0]   events;
    logic [SignalWidth-1:0] word;
  } decodedT;

  // Execute to result, one item per EAP hit
  typedef struct packed {
    logic                   valid;
    actionOpT               op;
    logic [1:0]             node;
    logic                   eap;
    logic [SignalWidth-1:0] word;
  } stepT;

endpackage

`default_nettype wire

//--- design/claEventDecode.sv
// First analyzer stage. Samples the debug word and the cross-trigger lines
// on every edge and presents the registered event bus one edge later.
// NumMatchSets + XtriggerWidth must equal NumEvents of the decodedT type.
// The registered word has no reset; only the events are cleared.

`timescale 1ns/10ps
`default_nettype none

module claEventDecode
  import claConfigPkg::*;
  import claPipePkg::decodedT;
#(
  parameter int SignalWidth   = claConfigPkg::SignalWidth,
  parameter int NumMatchSets  = claConfigPkg::NumMatchSets,
  parameter int XtriggerWidth = claConfigPkg::XtriggerWidth
) (
  input  wire logic                             gated_clock,
  input  wire logic                             reset_n,
  input  wire logic [SignalWidth-1:0]           debugSignals,
  input  wire logic [XtriggerWidth-1:0]         xtriggerIn,
  input  wire matchSetT [NumMatchSets-1:0]      matchSets,
  output decodedT                               decoded
);

  logic [NumMatchSets-1:0] matchHit;
  logic [SignalWidth-1:0]  maskedDiff;

  // ******************************
  // Mask/match compare
  // ******************************

  // Compared against the incoming word so the result lines up with
  // the word that gets registered beside it
  always_comb begin
    matchHit   = '0;
    maskedDiff = '0;
    for (int m = 0; m < NumMatchSets; m++) begin
      maskedDiff  = (debugSignals ^ matchSets[m].match) & matchSets[m].mask;
      matchHit[m] = (maskedDiff == '0);
    end
  end

  // ******************************
  // Event register
  // ******************************

  always_ff @(posedge gated_clock) begin
    decoded.word <= debugSignals;
    if (!reset_n) begin
      decoded.events <= '0;
    end else begin
      // Cross-triggers sit above the match sets
      decoded.events <= {xtriggerIn, matchHit};
    end
  end

endmodule

`default_nettype wire

//--- design/claNodeExecute.sv
// Second analyzer stage. Holds the current node and checks only the EAPs
// of that node against the decoded events. The lowest-index firing EAP
// wins and moves the chain to its next node.
// Status is sticky per node and EAP; a clear loses to a set in the same
// cycle. The step payload is not reset and is only meaningful with valid.

`timescale 1ns/10ps
`default_nettype none

module claNodeExecute
  import claConfigPkg::*;
  import claPipePkg::*;
#(
  parameter int NumNodes    = claConfigPkg::NumNodes,
  parameter int EapsPerNode = claConfigPkg::EapsPerNode,
  parameter int NumEvents   = claConfigPkg::NumEvents
) (
  input  wire logic                                    gated_clock,
  input  wire logic                                    reset_n,
  input  wire decodedT                                 decoded,
  input  wire eapConfigT [NumNodes-1:0][EapsPerNode-1:0] eapConfig,
  input  wire logic                                    enableEap,
  input  wire logic [NumNodes*EapsPerNode-1:0]         statusClear,
  output stepT                                         step,
  output logic [NumNodes*EapsPerNode-1:0]              eapStatus
);

  localparam int NodeBits = $clog2(NumNodes);
  localparam int EapBits  = (EapsPerNode > 1) ? $clog2(EapsPerNode) : 1;

  logic [NodeBits-1:0]               curNode;
  eapConfigT [EapsPerNode-1:0]       nodeEaps;
  logic [EapsPerNode-1:0]            eapFires;
  logic                              hit;
  logic [EapBits-1:0]                hitEap;
  eapConfigT                         hitCfg;
  logic [NumNodes*EapsPerNode-1:0]   setMask;

  // Only the current node's EAPs take part
  assign nodeEaps = eapConfig[curNode];

  always_comb begin
    eapFires = '0;
    for (int e = 0; e < EapsPerNode; e++) begin
      // Selects past the event bus never fire
      if (nodeEaps[e].enable && (nodeEaps[e].eventSel < NumEvents)) begin
        eapFires[e] = decoded.events[nodeEaps[e].eventSel];
      end
    end
  end

  // ******************************
  // Priority select
  // ******************************

  // Walk down so the lowest index is the one left standing
  always_comb begin
    hit    = 1'b0;
    hitEap = '0;
    hitCfg = '0;
    for (int e = EapsPerNode - 1; e >= 0; e--) begin
      if (enableEap && eapFires[e]) begin
        hit    = 1'b1;
        hitEap = EapBits'(e);
        hitCfg = nodeEaps[e];
      end
    end
  end

  always_comb begin
    setMask = '0;
    if (hit) begin
      setMask[curNode * EapsPerNode + hitEap] = 1'b1;
    end
  end

  // ******************************
  // Node, step and status
  // ******************************

  always_ff @(posedge gated_clock) begin
    step.op   <= actionOpT'(hitCfg.op);
    step.node <= curNode;
    step.eap  <= hitEap;
    step.word <= decoded.word;
    if (!reset_n) begin
      curNode    <= '0;
      step.valid <= 1'b0;
      eapStatus  <= '0;
    end else begin
      step.valid <= hit;
      if (hit) begin
        curNode <= NodeBits'(hitCfg.nextNode);
      end
      eapStatus <= (eapStatus & ~statusClear) | setMask;
    end
  end

endmodule

`default_nettype wire

//--- design/claActionResult.sv
// Last analyzer stage. Turns each valid step into sticky levels and
// one-cycle pulses, and captures the snapshot of the causing word.
// The halt is sticky until reset. The interrupt drops on any status clear
// unless a new interrupt op arrives in the same cycle.
// xtriggerOut is indexed by EAP, so EapsPerNode must not exceed XtriggerWidth.

`timescale 1ns/10ps
`default_nettype none

module claActionResult
  import claConfigPkg::*;
  import claPipePkg::*;
#(
  parameter int XtriggerWidth = claConfigPkg::XtriggerWidth,
  parameter int SignalWidth   = claConfigPkg::SignalWidth
) (
  input  wire logic                             gated_clock,
  input  wire logic                             reset_n,
  input  wire stepT                             step,
  input  wire logic                             haltEnable,
  input  wire logic [NumNodes*EapsPerNode-1:0]  statusClear,
  output logic                                  haltClock,
  output logic                                  debugInterrupt,
  output logic                                  traceActive,
  output logic [XtriggerWidth-1:0]              xtriggerOut,
  output logic                                  snapshotValid,
  output logic [SignalWidth-1:0]                snapshotData,
  output logic [1:0]                            snapshotNode,
  output logic                                  snapshotEap
);

  logic opHalt;
  logic opInterrupt;
  logic opTraceStart;
  logic opTraceStop;
  logic opXtrigger;
  logic anyClear;

  // ******************************
  // Opcode decode
  // ******************************
  assign opHalt       = step.valid && (step.op == actionHaltClock);
  assign opInterrupt  = step.valid && (step.op == actionDebugInterrupt);
  assign opTraceStart = step.valid && (step.op == actionTraceStart);
  assign opTraceStop  = step.valid && (step.op == actionTraceStop);
  assign opXtrigger   = step.valid && (step.op == actionXtrigger);
  assign anyClear     = |statusClear;

  // Sticky levels
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      haltClock      <= 1'b0;
      debugInterrupt <= 1'b0;
      traceActive    <= 1'b0;
    end else begin
      if (opHalt && haltEnable) begin
        haltClock <= 1'b1;
      end
      if (opInterrupt) begin
        debugInterrupt <= 1'b1;
      end else if (anyClear) begin
        debugInterrupt <= 1'b0;
      end
      if (opTraceStart) begin
        traceActive <= 1'b1;
      end else if (opTraceStop) begin
        traceActive <= 1'b0;
      end
    end
  end

  // ******************************
  // Pulses and snapshot
  // ******************************
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      xtriggerOut   <= '0;
      snapshotValid <= 1'b0;
      snapshotData  <= '0;
      snapshotNode  <= '0;
      snapshotEap   <= 1'b0;
    end else begin
      xtriggerOut <= '0;
      if (opXtrigger) begin
        xtriggerOut[step.eap] <= 1'b1;
      end
      snapshotValid <= step.valid;
      // Data holds the last hit between pulses
      if (step.valid) begin
        snapshotData <= step.word;
        snapshotNode <= step.node;
        snapshotEap  <= step.eap;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/coreLogicAnalyzer.sv
// Core logic analyzer: event decode, node chain execute and action result
// as three registered stages. Actions and snapshots follow the inputs
// after three edges, eapStatus after two.
// Requires EapsPerNode of at most XtriggerWidth.
// Has no clock-gating cell. It runs directly on the already gated clock.

`timescale 1ns/10ps
`default_nettype none

module coreLogicAnalyzer
  import claConfigPkg::*;
  import claPipePkg::*;
#(
  parameter int SignalWidth   = claConfigPkg::SignalWidth,
  parameter int NumMatchSets  = claConfigPkg::NumMatchSets,
  parameter int XtriggerWidth = claConfigPkg::XtriggerWidth,
  parameter int NumNodes      = claConfigPkg::NumNodes,
  parameter int EapsPerNode   = claConfigPkg::EapsPerNode,
  parameter int NumEvents     = claConfigPkg::NumEvents
) (
  input  wire logic                                      gated_clock,
  input  wire logic                                      reset_n,
  input  wire logic [SignalWidth-1:0]                    debugSignals,
  input  wire logic [XtriggerWidth-1:0]                  xtriggerIn,
  input  wire matchSetT [NumMatchSets-1:0]               matchSets,
  input  wire eapConfigT [NumNodes-1:0][EapsPerNode-1:0] eapConfig,
  input  wire claCtrlT                                   ctrl,
  input  wire logic [NumNodes*EapsPerNode-1:0]           statusClear,
  output logic [NumNodes*EapsPerNode-1:0]                eapStatus,
  output logic                                           haltClock,
  output logic                                           debugInterrupt,
  output logic                                           traceActive,
  output logic [XtriggerWidth-1:0]                       xtriggerOut,
  output logic                                           snapshotValid,
  output logic [SignalWidth-1:0]                         snapshotData,
  output logic [1:0]                                     snapshotNode,
  output logic                                           snapshotEap
);

  decodedT decoded;
  stepT    step;

  claEventDecode #(
    .SignalWidth   (SignalWidth),
    .NumMatchSets  (NumMatchSets),
    .XtriggerWidth (XtriggerWidth)
  ) u_decode (
    .gated_clock  (gated_clock),
    .reset_n      (reset_n),
    .debugSignals (debugSignals),
    .xtriggerIn   (xtriggerIn),
    .matchSets    (matchSets),
    .decoded      (decoded)
  );

  claNodeExecute #(
    .NumNodes    (NumNodes),
    .EapsPerNode (EapsPerNode),
    .NumEvents   (NumEvents)
  ) u_execute (
    .gated_clock (gated_clock),
    .reset_n     (reset_n),
    .decoded     (decoded),
    .eapConfig   (eapConfig),
    .enableEap   (ctrl.enableEap),
    .statusClear (statusClear),
    .step        (step),
    .eapStatus   (eapStatus)
  );

  claActionResult #(
    .XtriggerWidth (XtriggerWidth),
    .SignalWidth   (SignalWidth)
  ) u_result (
    .gated_clock    (gated_clock),
    .reset_n        (reset_n),
    .step           (step),
    .haltEnable     (ctrl.haltEnable),
    .statusClear    (statusClear),
    .haltClock      (haltClock),
    .debugInterrupt (debugInterrupt),
    .traceActive    (traceActive),
    .xtriggerOut    (xtriggerOut),
    .snapshotValid  (snapshotValid),
    .snapshotData   (snapshotData),
    .snapshotNode   (snapshotNode),
    .snapshotEap    (snapshotEap)
  );

endmodule

`default_nettype wire

//--- tests/coreLogicAnalyzer_props.sv
// Output properties of the analyzer, bound into the top level.
// newHit is the execute stage priority hit before its step register, so a
// repeated snapshot pulse is traced back two edges to a fresh hit.

`timescale 1ns/10ps
`default_nettype none

module coreLogicAnalyzerProps #(
  parameter int StatusWidth   = 8,
  parameter int XtriggerWidth = 2
) (
  input wire logic                     gated_clock,
  input wire logic                     reset_n,
  input wire logic [StatusWidth-1:0]   eapStatus,
  input wire logic                     haltClock,
  input wire logic                     debugInterrupt,
  input wire logic                     traceActive,
  input wire logic [XtriggerWidth-1:0] xtriggerOut,
  input wire logic                     snapshotValid,
  input wire logic                     newHit
);

  // Everything low on the edge after a reset edge
  resetClearsOutputs: assert property (@(posedge gated_clock)
    $past(!reset_n) |-> (eapStatus == '0) && !haltClock && !debugInterrupt
                        && !traceActive && (xtriggerOut == '0) && !snapshotValid)
    else $error("Outputs not low after reset");

  xtriggerOneHot: assert property (@(posedge gated_clock) disable iff (!reset_n)
    $onehot0(xtriggerOut))
    else $error("More than one xtriggerOut bit set");

  snapshotSinglePulse: assert property (@(posedge gated_clock) disable iff (!reset_n)
    snapshotValid && $past(snapshotValid) |-> $past(newHit, 2))
    else $error("snapshotValid held without a new hit");

endmodule

bind coreLogicAnalyzer coreLogicAnalyzerProps #(
  .StatusWidth   (NumNodes * EapsPerNode),
  .XtriggerWidth (XtriggerWidth)
) u_props (
  .gated_clock    (gated_clock),
  .reset_n        (reset_n),
  .eapStatus      (eapStatus),
  .haltClock      (haltClock),
  .debugInterrupt (debugInterrupt),
  .traceActive    (traceActive),
  .xtriggerOut    (xtriggerOut),
  .snapshotValid  (snapshotValid),
  .newHit         (u_execute.hit)
);

`default_nettype wire

//--- tests/claModel.svh
// Reference model of the analyzer, included inside the testbench module.
// It reads the testbench input variables directly and must be advanced
// once per rising edge, before the new inputs land.
// Each stage is updated from the values that stand before the edge, so
// predictions come out three edges after the inputs, status after two.

`ifndef CLA_MODEL_SVH
`define CLA_MODEL_SVH

// Decode stage
logic [NumEvents-1:0]   mEvents;
logic [SignalWidth-1:0] mWord;

// Execute stage
logic [1:0]             mNode;
stepT                   mStep;
logic [StatusWidth-1:0] mStatus;

// Result stage
logic                     mHalt;
logic                     mIrq;
logic                     mTrace;
logic [XtriggerWidth-1:0] mXtrig;
logic                     mSnapValid;
logic [SignalWidth-1:0]   mSnapData;
logic [1:0]               mSnapNode;
logic                     mSnapEap;

task automatic advanceModel();
  stepT      nextStep;
  eapConfigT cfg;
  logic      fired;
  logic [1:0] nextNode;
  nextStep = '0;
  fired    = 1'b0;
  nextNode = mNode;
  if (!reset_n) begin
    mEvents    = '0;
    mWord      = debugSignals;
    mNode      = '0;
    mStep      = '0;
    mStatus    = '0;
    mHalt      = 1'b0;
    mIrq       = 1'b0;
    mTrace     = 1'b0;
    mXtrig     = '0;
    mSnapValid = 1'b0;
    mSnapData  = '0;
    mSnapNode  = '0;
    mSnapEap   = 1'b0;
    return;
  end

  // ******************************
  // Result from the previous step
  // ******************************
  mXtrig     = '0;
  mSnapValid = mStep.valid;
  if (mStep.valid) begin
    mSnapData = mStep.word;
    mSnapNode = mStep.node;
    mSnapEap  = mStep.eap;
    case (mStep.op)
      actionHaltClock:  if (ctrl.haltEnable) mHalt = 1'b1;
      actionTraceStart: mTrace = 1'b1;
      actionTraceStop:  mTrace = 1'b0;
      actionXtrigger:   mXtrig[mStep.eap] = 1'b1;
      default:          ;
    endcase
  end
  if (mStep.valid && (mStep.op == actionDebugInterrupt)) begin
    mIrq = 1'b1;
  end else if (statusClear != '0) begin
    mIrq = 1'b0;
  end

  // ******************************
  // Execute on the previous events
  // ******************************
  mStatus = mStatus & ~statusClear;
  for (int e = 0; e < EapsPerNode; e++) begin
    cfg = eapConfig[mNode][e];
    if (!fired && ctrl.enableEap && cfg.enable && (int'(cfg.eventSel) < NumEvents)
        && mEvents[cfg.eventSel]) begin
      fired          = 1'b1;
      nextStep.valid = 1'b1;
      nextStep.op    = actionOpT'(cfg.op);
      nextStep.node  = mNode;
      nextStep.eap   = 1'(e);
      nextStep.word  = mWord;
      nextNode       = cfg.nextNode;
      // Set after the clear so a same-cycle set wins
      mStatus = mStatus | (StatusWidth'(1) << (mNode * EapsPerNode + e));
    end
  end
  mStep = nextStep;
  mNode = nextNode;

  // Decode of the sampled inputs
  mWord = debugSignals;
  for (int m = 0; m < NumMatchSets; m++) begin
    mEvents[m] = ((debugSignals & matchSets[m].mask) == (matchSets[m].match & matchSets[m].mask));
  end
  mEvents[NumEvents-1:NumMatchSets] = xtriggerIn;
endtask

`endif

//--- tests/coreLogicAnalyzerTb.sv
// Random regression of the core logic analyzer against the model in
// claModel.svh. Inputs change on the rising edge, outputs are compared
// on every falling edge, one reset at the start and one mid-run.
// Configuration changes every 200 cycles while the chain keeps running.

`timescale 1ns/10ps
`default_nettype none

module coreLogicAnalyzerTb
  import claConfigPkg::*;
  import claPipePkg::*;
();

  localparam int StatusWidth    = NumNodes * EapsPerNode;
  localparam int NumCycles      = 3000;
  localparam int ReconfigPeriod = 200;
  localparam int ResetCycle     = 1500;
  // Run length plus margin
  localparam int CycleLimit     = NumCycles + 1000;

  logic                                      gated_clock;
  logic                                      reset_n;
  logic [SignalWidth-1:0]                    debugSignals;
  logic [XtriggerWidth-1:0]                  xtriggerIn;
  matchSetT [NumMatchSets-1:0]               matchSets;
  eapConfigT [NumNodes-1:0][EapsPerNode-1:0] eapConfig;
  claCtrlT                                   ctrl;
  logic [StatusWidth-1:0]                    statusClear;
  logic [StatusWidth-1:0]                    eapStatus;
  logic                                      haltClock;
  logic                                      debugInterrupt;
  logic                                      traceActive;
  logic [XtriggerWidth-1:0]                  xtriggerOut;
  logic                                      snapshotValid;
  logic [SignalWidth-1:0]                    snapshotData;
  logic [1:0]                                snapshotNode;
  logic                                      snapshotEap;
  int                                        cycles = 0;
  int                                        checks = 0;
  int                                        errors = 0;
  int                                        enableHold;

  `include "claModel.svh"

  coreLogicAnalyzer u_dut (
    .gated_clock    (gated_clock),
    .reset_n        (reset_n),
    .debugSignals   (debugSignals),
    .xtriggerIn     (xtriggerIn),
    .matchSets      (matchSets),
    .eapConfig      (eapConfig),
    .ctrl           (ctrl),
    .statusClear    (statusClear),
    .eapStatus      (eapStatus),
    .haltClock      (haltClock),
    .debugInterrupt (debugInterrupt),
    .traceActive    (traceActive),
    .xtriggerOut    (xtriggerOut),
    .snapshotValid  (snapshotValid),
    .snapshotData   (snapshotData),
    .snapshotNode   (snapshotNode),
    .snapshotEap    (snapshotEap)
  );

  always #10 gated_clock = ~gated_clock;

  always @(posedge gated_clock) begin
    cycles <= cycles + 1;
  end

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s cycle %0d: expected %h actual %h", name, cycles, expected, actual);
    end
  endtask

  // Sparse masks keep the match sets hitting often
  task automatic randomizeConfig();
    matchSetT [NumMatchSets-1:0]               sets;
    eapConfigT [NumNodes-1:0][EapsPerNode-1:0] eaps;
    logic [SignalWidth-1:0]                    mask;
    for (int m = 0; m < NumMatchSets; m++) begin
      mask = SignalWidth'(1) << $urandom_range(0, SignalWidth - 1);
      mask = mask | (SignalWidth'($urandom_range(0, 1)) << $urandom_range(0, SignalWidth - 1));
      sets[m].mask  = mask;
      sets[m].match = SignalWidth'($urandom);
    end
    for (int n = 0; n < NumNodes; n++) begin
      for (int e = 0; e < EapsPerNode; e++) begin
        eaps[n][e].enable   = ($urandom_range(0, 7) != 0);
        eaps[n][e].eventSel = 3'($urandom);
        eaps[n][e].op       = 3'($urandom_range(0, 5));
        eaps[n][e].nextNode = 2'($urandom);
      end
    end
    matchSets       <= sets;
    eapConfig       <= eaps;
    ctrl.haltEnable <= ($urandom_range(0, 3) == 0);
  endtask

  // ******************************
  // Stimulus and model step
  // ******************************
  always @(posedge gated_clock) begin
    advanceModel();
    debugSignals <= SignalWidth'($urandom);
    xtriggerIn   <= XtriggerWidth'($urandom);
    if (cycles % ReconfigPeriod == 0) begin
      randomizeConfig();
    end
    if ($urandom_range(0, 19) == 0) begin
      statusClear <= StatusWidth'($urandom);
    end else begin
      statusClear <= '0;
    end
    // Short low stretches, long high ones
    if (enableHold == 0) begin
      ctrl.enableEap <= !ctrl.enableEap;
      enableHold     <= ctrl.enableEap ? $urandom_range(2, 15) : $urandom_range(20, 80);
    end else begin
      enableHold <= enableHold - 1;
    end
  end

  always @(negedge gated_clock) begin
    if (cycles > 0) begin
      compareValue("chain snapshotValid", 32'(mSnapValid), 32'(snapshotValid));
      compareValue("chain snapshotNode", 32'(mSnapNode), 32'(snapshotNode));
      compareValue("chain snapshotEap", 32'(mSnapEap), 32'(snapshotEap));
      compareValue("chain snapshotData", 32'(mSnapData), 32'(snapshotData));
      compareValue("status eapStatus", 32'(mStatus), 32'(eapStatus));
      compareValue("halt haltClock", 32'(mHalt), 32'(haltClock));
      compareValue("interrupt debugInterrupt", 32'(mIrq), 32'(debugInterrupt));
      compareValue("trace traceActive", 32'(mTrace), 32'(traceActive));
      compareValue("xtrigger xtriggerOut", 32'(mXtrig), 32'(xtriggerOut));
    end
  end

  initial begin
    while (cycles < CycleLimit) @(posedge gated_clock);
    $display("Timeout: run still going after %0d cycles", CycleLimit);
    $display("Regression failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hb614_fad0));
    gated_clock  = 1'b0;
    reset_n      = 1'b0;
    debugSignals = '0;
    xtriggerIn   = '0;
    matchSets    = '0;
    eapConfig    = '0;
    ctrl         = '0;
    statusClear  = '0;
    enableHold   = 0;
    repeat (2) @(posedge gated_clock);
    reset_n <= 1'b1;
    while (cycles != ResetCycle) @(posedge gated_clock);
    reset_n <= 1'b0;
    repeat (2) @(posedge gated_clock);
    reset_n <= 1'b1;
    while (cycles < NumCycles) @(posedge gated_clock);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+tests
design/claConfigPkg.sv
design/claPipePkg.sv
design/claEventDecode.sv
design/claNodeExecute.sv
design/claActionResult.sv
design/coreLogicAnalyzer.sv
tests/coreLogicAnalyzer_props.sv
tests/coreLogicAnalyzerTb.sv

//--- Makefile
# Verilator flow for the core logic analyzer

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module coreLogicAnalyzer

sim:
	verilator --binary --timing --assert -f project.f --top-module coreLogicAnalyzerTb \
		--Mdir obj_dir -o simv
	./obj_dir/simv > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG) || \
	   ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
